// ==== verilog/simd_pkg.sv ====
package simd_pkg;

    // Datapath widths
    localparam int data_width = 18;
    localparam int mem_data_width = 9;

    // Threads held in each lane
    localparam int thread_count = 4;
    localparam int thread_width = 2;

    // Registers per thread
    localparam int reg_count = 16;
    localparam int reg_addr_width = 4;

    localparam int block_idx_width = 18;

    // Lanes in the core
    localparam int lane_count = 2;

    // Stages between the result stage and the writeback register
    localparam int wb_delay = 3;

    // Special register that reads as the global lane id
    localparam int lane_id_reg = 1;

    // Shift amount is taken from the low bits of operand b
    localparam int shamt_width = 5;

    // Integer opcodes
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_shl = 4'd5,
        op_shr = 4'd6,
        // Unsigned less-than, 1 or 0
        op_slt = 4'd7,
        // Equality, 1 or 0
        op_seq = 4'd8
    } alu_op_e;

endpackage

// ==== verilog/lane_regfile.sv ====
`timescale 1ns/1ps

module lane_regfile #(
    parameter int lane_idx = 0
) (
    input  logic clk,
    input  logic [simd_pkg::thread_width-1:0] read_thread,
    input  logic [simd_pkg::reg_addr_width-1:0] rs1,
    input  logic [simd_pkg::reg_addr_width-1:0] rs2,
    input  logic [simd_pkg::block_idx_width-1:0] block_idx,
    input  logic write_en,
    input  logic pred_write_en,
    input  logic [simd_pkg::thread_width-1:0] write_thread,
    input  logic [simd_pkg::reg_addr_width-1:0] write_rd,
    input  logic [simd_pkg::data_width-1:0] write_data,
    input  logic pred_in,
    output logic [simd_pkg::data_width-1:0] reg1,
    output logic [simd_pkg::data_width-1:0] reg2,
    output logic pred_out
);

    // One register bank and one predicate bit per thread
    logic [simd_pkg::data_width-1:0] regs [simd_pkg::thread_count][simd_pkg::reg_count];
    logic [simd_pkg::thread_count-1:0] pred;

    logic [simd_pkg::data_width-1:0] lane_id;
    logic write_allowed;

    // Global lane id, block index scaled by the lane count
    assign lane_id = simd_pkg::data_width'(block_idx) *
                     simd_pkg::data_width'(simd_pkg::lane_count) +
                     simd_pkg::data_width'(lane_idx);

    function automatic logic [simd_pkg::data_width-1:0] read_port(
        input logic [simd_pkg::reg_addr_width-1:0] addr
    );
        logic [simd_pkg::data_width-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (addr == simd_pkg::reg_addr_width'(simd_pkg::lane_id_reg)) begin
            value = lane_id;
        end else begin
            value = regs[read_thread][addr];
        end
        return value;
    endfunction

    always_comb begin
        reg1 = read_port(rs1);
        reg2 = read_port(rs2);
        pred_out = pred[read_thread];
    end

    // Zero and lane-id registers are read only
    assign write_allowed = write_en && (write_rd != '0) &&
        (write_rd != simd_pkg::reg_addr_width'(simd_pkg::lane_id_reg));

    always_ff @(posedge clk) begin
        if (write_allowed) begin
            regs[write_thread][write_rd] <= write_data;
        end
        if (pred_write_en) begin
            pred[write_thread] <= pred_in;
        end
    end

endmodule

// ==== verilog/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
    input  logic [simd_pkg::data_width-1:0] reg1,
    input  logic [simd_pkg::data_width-1:0] reg2,
    input  logic [simd_pkg::data_width-1:0] imm,
    input  logic is_imm,
    input  simd_pkg::alu_op_e op,
    output logic [simd_pkg::data_width-1:0] result
);

    logic [simd_pkg::data_width-1:0] op_b;
    logic [simd_pkg::shamt_width-1:0] shamt;

    // Second operand from the immediate or the register
    assign op_b = is_imm ? imm : reg2;
    assign shamt = op_b[simd_pkg::shamt_width-1:0];

    always_comb begin
        case (op)
            simd_pkg::op_add: begin
                result = reg1 + op_b;
            end
            simd_pkg::op_sub: begin
                result = reg1 - op_b;
            end
            simd_pkg::op_and: begin
                result = reg1 & op_b;
            end
            simd_pkg::op_or: begin
                result = reg1 | op_b;
            end
            simd_pkg::op_xor: begin
                result = reg1 ^ op_b;
            end
            simd_pkg::op_shl: begin
                result = reg1 << shamt;
            end
            // Logical shift, zeros enter from the top
            simd_pkg::op_shr: begin
                result = reg1 >> shamt;
            end
            simd_pkg::op_slt: begin
                result = simd_pkg::data_width'(reg1 < op_b);
            end
            simd_pkg::op_seq: begin
                result = simd_pkg::data_width'(reg1 == op_b);
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== verilog/simd_lane.sv ====
`timescale 1ns/1ps

module simd_lane #(
    parameter int lane_idx = 0
) (
    input  logic clk,
    input  logic rst_n,
    input  logic issue,
    input  logic stall,
    input  logic [simd_pkg::thread_width-1:0] thread_num,
    input  logic [simd_pkg::block_idx_width-1:0] block_idx,
    input  simd_pkg::alu_op_e op,
    input  logic [simd_pkg::data_width-1:0] imm,
    input  logic [simd_pkg::reg_addr_width-1:0] rs1,
    input  logic [simd_pkg::reg_addr_width-1:0] rs2,
    input  logic [simd_pkg::reg_addr_width-1:0] rd,
    input  logic is_int,
    input  logic is_imm,
    input  logic is_mem,
    input  logic is_memwrite,
    input  logic is_pred_set,
    input  logic is_pred_get,
    input  logic [simd_pkg::mem_data_width-1:0] mem_read_data,
    output logic mem_write_en,
    output logic [simd_pkg::data_width-1:0] mem_addr,
    output logic [simd_pkg::mem_data_width-1:0] mem_write_data
);

    // Register file read side
    logic [simd_pkg::data_width-1:0] rf_reg1;
    logic [simd_pkg::data_width-1:0] rf_reg2;
    logic rf_pred;

    // Operand latch
    logic op_valid;
    simd_pkg::alu_op_e op_op;
    logic [simd_pkg::data_width-1:0] op_imm;
    logic [simd_pkg::data_width-1:0] op_reg1;
    logic [simd_pkg::data_width-1:0] op_reg2;
    logic [simd_pkg::reg_addr_width-1:0] op_rd;
    logic [simd_pkg::thread_width-1:0] op_thread;
    logic op_is_int;
    logic op_is_imm;
    logic op_is_mem;
    logic op_is_memwrite;
    logic op_is_pred_set;
    logic op_guard;
    logic op_is_load;

    logic [simd_pkg::data_width-1:0] alu_result;

    // Result stage
    logic res_valid;
    logic [simd_pkg::data_width-1:0] res_result;
    logic res_is_load;
    logic [simd_pkg::reg_addr_width-1:0] res_rd;
    logic [simd_pkg::thread_width-1:0] res_thread;
    logic res_regwrite;
    logic res_pred_write;
    logic [simd_pkg::data_width-1:0] res_data;

    // Delay line, index 0 is the youngest
    logic [simd_pkg::wb_delay-1:0] dl_valid;
    logic [simd_pkg::wb_delay-1:0] dl_regwrite;
    logic [simd_pkg::wb_delay-1:0] dl_pred_write;
    logic [simd_pkg::wb_delay-1:0] dl_pred_val;
    logic [simd_pkg::data_width-1:0] dl_data [simd_pkg::wb_delay];
    logic [simd_pkg::reg_addr_width-1:0] dl_rd [simd_pkg::wb_delay];
    logic [simd_pkg::thread_width-1:0] dl_thread [simd_pkg::wb_delay];

    // Writeback register
    logic wb_valid;
    logic wb_regwrite;
    logic wb_pred_write;
    logic wb_pred_val;
    logic [simd_pkg::data_width-1:0] wb_data;
    logic [simd_pkg::reg_addr_width-1:0] wb_rd;
    logic [simd_pkg::thread_width-1:0] wb_thread;

    lane_regfile #(
        .lane_idx(lane_idx)
    ) regfile_i (
        .clk(clk),
        .read_thread(thread_num),
        .rs1(rs1),
        .rs2(rs2),
        .block_idx(block_idx),
        .write_en(wb_valid & wb_regwrite),
        .pred_write_en(wb_valid & wb_pred_write),
        .write_thread(wb_thread),
        .write_rd(wb_rd),
        .write_data(wb_data),
        .pred_in(wb_pred_val),
        .reg1(rf_reg1),
        .reg2(rf_reg2),
        .pred_out(rf_pred)
    );

    int_alu alu_i (
        .reg1(op_reg1),
        .reg2(op_reg2),
        .imm(op_imm),
        .is_imm(op_is_imm),
        .op(op_op),
        .result(alu_result)
    );

    // Valid is a one-cycle pulse, payload holds under stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_valid <= 1'b0;
            op_op <= simd_pkg::op_add;
            op_imm <= '0;
            op_reg1 <= '0;
            op_reg2 <= '0;
            op_rd <= '0;
            op_thread <= '0;
            op_is_int <= 1'b0;
            op_is_imm <= 1'b0;
            op_is_mem <= 1'b0;
            op_is_memwrite <= 1'b0;
            op_is_pred_set <= 1'b0;
            op_guard <= 1'b0;
        end else begin
            op_valid <= issue & ~stall;
            if (issue && !stall) begin
                op_op <= op;
                op_imm <= imm;
                op_reg1 <= rf_reg1;
                op_reg2 <= rf_reg2;
                op_rd <= rd;
                op_thread <= thread_num;
                op_is_int <= is_int;
                op_is_imm <= is_imm;
                op_is_mem <= is_mem;
                op_is_memwrite <= is_memwrite;
                op_is_pred_set <= is_pred_set;
                // Unguarded unless the thread predicate is requested
                op_guard <= ~is_pred_get | rf_pred;
            end
        end
    end

    assign op_is_load = op_is_mem & ~op_is_memwrite;

    // Memory port
    assign mem_write_en = op_valid & op_is_mem & op_is_memwrite & op_guard;
    assign mem_addr = op_reg1;
    assign mem_write_data = op_reg2[simd_pkg::mem_data_width-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        res_result <= alu_result;
        res_is_load <= op_is_load;
        res_rd <= op_rd;
        res_thread <= op_thread;
        res_regwrite <= op_guard & (op_is_int | op_is_load);
        res_pred_write <= op_guard & op_is_int & op_is_pred_set;
    end

    // Load data arrives during the result stage
    assign res_data = res_is_load ?
        {{(simd_pkg::data_width - simd_pkg::mem_data_width){1'b0}}, mem_read_data} :
        res_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dl_valid <= '0;
            wb_valid <= 1'b0;
        end else begin
            dl_valid <= {dl_valid[simd_pkg::wb_delay-2:0], res_valid};
            wb_valid <= dl_valid[simd_pkg::wb_delay-1];
        end
    end

    always_ff @(posedge clk) begin
        dl_regwrite <= {dl_regwrite[simd_pkg::wb_delay-2:0], res_regwrite};
        dl_pred_write <= {dl_pred_write[simd_pkg::wb_delay-2:0], res_pred_write};
        dl_pred_val <= {dl_pred_val[simd_pkg::wb_delay-2:0], res_result[0]};
        dl_data[0] <= res_data;
        dl_rd[0] <= res_rd;
        dl_thread[0] <= res_thread;
        for (int i = 1; i < simd_pkg::wb_delay; i++) begin
            dl_data[i] <= dl_data[i-1];
            dl_rd[i] <= dl_rd[i-1];
            dl_thread[i] <= dl_thread[i-1];
        end
        // Writeback register takes the oldest stage
        wb_regwrite <= dl_regwrite[simd_pkg::wb_delay-1];
        wb_pred_write <= dl_pred_write[simd_pkg::wb_delay-1];
        wb_pred_val <= dl_pred_val[simd_pkg::wb_delay-1];
        wb_data <= dl_data[simd_pkg::wb_delay-1];
        wb_rd <= dl_rd[simd_pkg::wb_delay-1];
        wb_thread <= dl_thread[simd_pkg::wb_delay-1];
    end

endmodule

// ==== verilog/simd_core.sv ====
`timescale 1ns/1ps

module simd_core (
    input  logic clk,
    input  logic rst_n,
    input  logic issue,
    input  logic stall,
    input  logic [simd_pkg::thread_width-1:0] thread_num,
    input  logic [simd_pkg::block_idx_width-1:0] block_idx,
    input  simd_pkg::alu_op_e op,
    input  logic [simd_pkg::data_width-1:0] imm,
    input  logic [simd_pkg::reg_addr_width-1:0] rs1,
    input  logic [simd_pkg::reg_addr_width-1:0] rs2,
    input  logic [simd_pkg::reg_addr_width-1:0] rd,
    input  logic is_int,
    input  logic is_imm,
    input  logic is_mem,
    input  logic is_memwrite,
    input  logic is_pred_set,
    input  logic is_pred_get,
    input  logic [simd_pkg::lane_count*simd_pkg::mem_data_width-1:0] mem_read_data,
    output logic [simd_pkg::lane_count-1:0] mem_write_en,
    output logic [simd_pkg::lane_count*simd_pkg::data_width-1:0] mem_addr,
    output logic [simd_pkg::lane_count*simd_pkg::mem_data_width-1:0] mem_write_data
);

    // Same instruction to every lane, slice g of each memory bus to lane g
    for (genvar g = 0; g < simd_pkg::lane_count; g++) begin : gen_lane
        simd_lane #(
            .lane_idx(g)
        ) lane_i (
            .clk(clk),
            .rst_n(rst_n),
            .issue(issue),
            .stall(stall),
            .thread_num(thread_num),
            .block_idx(block_idx),
            .op(op),
            .imm(imm),
            .rs1(rs1),
            .rs2(rs2),
            .rd(rd),
            .is_int(is_int),
            .is_imm(is_imm),
            .is_mem(is_mem),
            .is_memwrite(is_memwrite),
            .is_pred_set(is_pred_set),
            .is_pred_get(is_pred_get),
            .mem_read_data(mem_read_data[g*simd_pkg::mem_data_width +: simd_pkg::mem_data_width]),
            .mem_write_en(mem_write_en[g]),
            .mem_addr(mem_addr[g*simd_pkg::data_width +: simd_pkg::data_width]),
            .mem_write_data(mem_write_data[g*simd_pkg::mem_data_width +: simd_pkg::mem_data_width])
        );
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam time half_period = 10ns;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release shortly after the edge, like every other driven input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

// ==== dv/simd_core_asserts.sv ====
`timescale 1ns/1ps

module simd_core_asserts (
    input logic clk,
    input logic rst_n,
    input logic stall,
    input logic [simd_pkg::lane_count-1:0] mem_write_en,
    input logic [simd_pkg::lane_count*simd_pkg::data_width-1:0] mem_addr,
    input logic [simd_pkg::lane_count*simd_pkg::mem_data_width-1:0] mem_write_data
);

    // Failed checks counted for the testbench summary
    int failure_count = 0;

    // Pipeline is empty right after reset
    no_store_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (mem_write_en == '0)
    ) else begin
        $error("Store strobe high in the first cycle after reset");
        failure_count++;
    end

    // A held instruction stores only once
    single_store_under_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (stall && (mem_write_en != '0)) |=> (mem_write_en == '0)
    ) else begin
        $error("Store strobe high on two cycles in a row during stall");
        failure_count++;
    end

    outputs_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({mem_write_en, mem_addr, mem_write_data})
    ) else begin
        $error("Unknown value on a memory port output");
        failure_count++;
    end

endmodule

// ==== dv/simd_core_tb.sv ====
`timescale 1ns/1ps

module simd_core_tb;

    localparam int max_lines = 64;
    localparam int lanes = simd_pkg::lane_count;
    localparam int mdw = simd_pkg::mem_data_width;
    localparam int dw = simd_pkg::data_width;

    logic clk;
    logic rst_n;
    logic issue;
    logic stall;
    logic [simd_pkg::thread_width-1:0] thread_num;
    logic [simd_pkg::block_idx_width-1:0] block_idx;
    simd_pkg::alu_op_e op;
    logic [dw-1:0] imm;
    logic [simd_pkg::reg_addr_width-1:0] rs1;
    logic [simd_pkg::reg_addr_width-1:0] rs2;
    logic [simd_pkg::reg_addr_width-1:0] rd;
    logic is_int;
    logic is_imm;
    logic is_mem;
    logic is_memwrite;
    logic is_pred_set;
    logic is_pred_get;
    logic [lanes*mdw-1:0] mem_read_data = '0;
    logic [lanes-1:0] mem_write_en;
    logic [lanes*dw-1:0] mem_addr;
    logic [lanes*mdw-1:0] mem_write_data;

    // Program as read from the input file
    string name_a [max_lines];
    logic stall_a [max_lines];
    logic [simd_pkg::thread_width-1:0] thread_a [max_lines];
    logic [simd_pkg::block_idx_width-1:0] block_a [max_lines];
    logic [3:0] op_a [max_lines];
    logic [dw-1:0] imm_a [max_lines];
    logic [simd_pkg::reg_addr_width-1:0] rs1_a [max_lines];
    logic [simd_pkg::reg_addr_width-1:0] rs2_a [max_lines];
    logic [simd_pkg::reg_addr_width-1:0] rd_a [max_lines];
    logic [5:0] flags_a [max_lines];
    logic [lanes-1:0] mask_a [max_lines];
    logic [mdw-1:0] store_a [max_lines][lanes];
    int line_count = 0;
    logic loaded = 1'b0;

    // Outstanding stores per lane
    logic [mdw-1:0] exp_data_q [lanes][$];
    string exp_name_q [lanes][$];

    int mismatch_count = 0;
    int missing_count = 0;
    int extra_count = 0;
    int other_count = 0;

    logic [dw-1:0] addr_seen [lanes] = '{default: '0};

    tb_clock_gen clock_gen_i (
        .clk(clk),
        .rst_n(rst_n)
    );

    simd_core simd_core_i (
        .clk(clk),
        .rst_n(rst_n),
        .issue(issue),
        .stall(stall),
        .thread_num(thread_num),
        .block_idx(block_idx),
        .op(op),
        .imm(imm),
        .rs1(rs1),
        .rs2(rs2),
        .rd(rd),
        .is_int(is_int),
        .is_imm(is_imm),
        .is_mem(is_mem),
        .is_memwrite(is_memwrite),
        .is_pred_set(is_pred_set),
        .is_pred_get(is_pred_get),
        .mem_read_data(mem_read_data),
        .mem_write_en(mem_write_en),
        .mem_addr(mem_addr),
        .mem_write_data(mem_write_data)
    );

    bind simd_core simd_core_asserts asserts_i (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .mem_write_en(mem_write_en),
        .mem_addr(mem_addr),
        .mem_write_data(mem_write_data)
    );

    // Memory contents are a fixed function of address and lane
    function automatic logic [mdw-1:0] memory_value(input logic [dw-1:0] addr, input int lane);
        logic [dw-1:0] mixed;
        mixed = addr ^ dw'(lane * 'h55);
        return mixed[mdw-1:0];
    endfunction

    task automatic read_program();
        int fd;
        int fields;
        string text;
        fd = $fopen("dv/simd_core_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the input file dv/simd_core_input.txt");
            other_count++;
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (text.len() < 2 || text.getc(0) == 8'h23) begin
                    continue;
                end
                if (line_count >= max_lines) begin
                    $display("Input file has more than %0d instructions", max_lines);
                    other_count++;
                    break;
                end
                fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                    name_a[line_count], stall_a[line_count], thread_a[line_count],
                    block_a[line_count], op_a[line_count], imm_a[line_count],
                    rs1_a[line_count], rs2_a[line_count], rd_a[line_count],
                    flags_a[line_count], mask_a[line_count],
                    store_a[line_count][0], store_a[line_count][1]);
                if (fields != 13) begin
                    $display("Malformed input line: %s", text);
                    other_count++;
                end else begin
                    line_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_line(input int idx);
        thread_num = thread_a[idx];
        block_idx = block_a[idx];
        op = simd_pkg::alu_op_e'(op_a[idx]);
        imm = imm_a[idx];
        rs1 = rs1_a[idx];
        rs2 = rs2_a[idx];
        rd = rd_a[idx];
        // Flags packed in file order with is_int on top
        {is_int, is_imm, is_mem, is_memwrite, is_pred_set, is_pred_get} = flags_a[idx];
        issue = 1'b1;
    endtask

    task automatic expect_stores(input int idx);
        for (int l = 0; l < lanes; l++) begin
            if (mask_a[idx][l]) begin
                exp_data_q[l].push_back(store_a[idx][l]);
                exp_name_q[l].push_back(name_a[idx]);
            end
        end
    endtask

    initial begin
        int stall_cycles;
        int assert_count;
        issue = 1'b0;
        stall = 1'b0;
        thread_num = '0;
        block_idx = '0;
        op = simd_pkg::op_add;
        imm = '0;
        rs1 = '0;
        rs2 = '0;
        rd = '0;
        {is_int, is_imm, is_mem, is_memwrite, is_pred_set, is_pred_get} = '0;
        void'($urandom(9));
        read_program();
        loaded = 1'b1;

        wait (rst_n === 1'b1);
        for (int i = 0; i < line_count; i++) begin
            if (stall_a[i]) begin
                stall_cycles = 1 + int'($urandom % 3);
                repeat (stall_cycles) begin
                    @(posedge clk);
                    #2;
                    apply_line(i);
                    stall = 1'b1;
                end
            end
            @(posedge clk);
            #2;
            apply_line(i);
            stall = 1'b0;
            expect_stores(i);
        end
        @(posedge clk);
        #2;
        issue = 1'b0;
        repeat (simd_pkg::wb_delay + 10) @(posedge clk);

        for (int l = 0; l < lanes; l++) begin
            stores_drained: assert (exp_data_q[l].size() == 0) else begin
                while (exp_data_q[l].size() > 0) begin
                    $display("Store for %s never appeared on lane %0d",
                        exp_name_q[l].pop_front(), l);
                    void'(exp_data_q[l].pop_front());
                    missing_count++;
                end
            end
        end

        assert_count = simd_core_i.asserts_i.failure_count;
        $display({"Errors: %0d mismatches, %0d missing stores, %0d extra stores, ",
            "%0d assertion failures, %0d other"},
            mismatch_count, missing_count, extra_count, assert_count, other_count);
        if (mismatch_count + missing_count + extra_count + assert_count + other_count == 0)
        begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Store check in mid cycle where the port is stable
    always @(negedge clk) begin
        logic [mdw-1:0] expected;
        logic [mdw-1:0] actual;
        string name;
        if (rst_n) begin
            for (int l = 0; l < lanes; l++) begin
                if (mem_write_en[l]) begin
                    actual = mem_write_data[l*mdw +: mdw];
                    store_expected: assert (exp_data_q[l].size() > 0) else begin
                        $display("Unexpected store on lane %0d with data %h", l, actual);
                        extra_count++;
                    end
                    if (exp_data_q[l].size() > 0) begin
                        expected = exp_data_q[l].pop_front();
                        name = exp_name_q[l].pop_front();
                        store_check: assert (actual == expected) else begin
                            $display("Mismatch %s lane %0d: expected %h, actual %h",
                                name, l, expected, actual);
                            mismatch_count++;
                        end
                    end
                end
            end
        end
    end

    // Memory model samples the address mid cycle and answers one cycle later
    always @(negedge clk) begin
        for (int l = 0; l < lanes; l++) begin
            addr_seen[l] <= mem_addr[l*dw +: dw];
        end
    end

    always @(posedge clk) begin
        #2;
        for (int l = 0; l < lanes; l++) begin
            mem_read_data[l*mdw +: mdw] = memory_value(addr_seen[l], l);
        end
    end

    // Watchdog scaled by the program length
    initial begin
        int limit;
        wait (loaded);
        limit = (line_count + 20) * 8;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/simd_pkg.sv
verilog/lane_regfile.sv
verilog/int_alu.sv
verilog/simd_lane.sv
verilog/simd_core.sv
dv/tb_clock_gen.sv
dv/simd_core_asserts.sv
dv/simd_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := simd_core_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

SRCS := $(wildcard verilog/*.sv) $(wildcard dv/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output goes to the terminal only, the status comes from the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/simd_core_input.txt ====
# name stall thread block op imm rs1 rs2 rd flags(int imm mem memwr pset pget) mask st0 st1
# all numbers hex, mask bit n means lane n stores st<n>
imm_setup      0 0 5 0 0b6 0 0 2 30 0 000 000
imm_setup      0 0 5 0 02d 0 0 3 30 0 000 000
thread1        0 1 5 0 077 0 0 2 30 0 000 000
thread2        0 2 5 0 1ee 0 0 2 30 0 000 000
pred_write     0 0 5 0 033 0 0 c 30 0 000 000
zero_reg       0 0 5 0 055 0 0 0 30 0 000 000
lane_id        0 0 5 0 044 0 0 1 30 0 000 000
pred_set       0 0 5 7 00b 1 0 b 32 0 000 000
load           0 0 5 0 000 1 0 d 08 0 000 000
imm_sub        0 0 5 1 016 2 0 4 30 0 000 000
imm_and        0 0 5 2 00f 2 0 5 30 0 000 000
imm_or         0 0 5 3 100 2 0 6 30 0 000 000
imm_xor        0 0 5 4 1ff 2 0 7 30 0 000 000
imm_shl        0 0 5 5 002 2 0 8 30 0 000 000
imm_shr        0 0 5 6 003 2 0 9 30 0 000 000
reg_add        0 0 5 0 000 2 3 a 20 0 000 000
pred_write     0 0 5 0 1a5 0 0 c 31 0 000 000
stall_write    1 0 5 0 0c3 0 0 e 30 0 000 000
pred_store     0 0 5 0 000 0 2 0 0d 1 0b6 000
imm_sub        0 0 5 0 000 0 4 0 0c 3 0a0 0a0
imm_and        0 0 5 0 000 0 5 0 0c 3 006 006
imm_or         0 0 5 0 000 0 6 0 0c 3 1b6 1b6
imm_xor        0 0 5 0 000 0 7 0 0c 3 149 149
imm_shl        0 0 5 0 000 0 8 0 0c 3 0d8 0d8
imm_shr        0 0 5 0 000 0 9 0 0c 3 016 016
reg_add        0 0 5 0 000 0 a 0 0c 3 0e3 0e3
lane_id        0 0 5 0 000 0 1 0 0c 3 00a 00b
zero_reg       0 0 5 0 000 0 0 0 0c 3 000 000
thread1        0 1 5 0 000 0 2 0 0c 3 077 077
thread2        1 2 5 0 000 0 2 0 0c 3 1ee 1ee
pred_set       0 0 5 0 000 0 b 0 0c 3 001 000
pred_write     0 0 5 0 000 0 c 0 0c 3 1a5 033
load           0 0 5 0 000 0 d 0 0c 3 00a 05e
stall_write    0 0 5 0 000 0 e 0 0c 3 0c3 0c3
